// ==== rtl/mpu_params.svh ====
/*
  Sizing for the MPU. Address and data widths are fixed at 32 bits in
  practice, since the region table holds 30-bit word addresses.
  The outstanding limit only throttles new core requests. One more
  request may still sit in the bus stage when the limit is reached.
*/

`ifndef MPU_PARAMS_SVH
`define MPU_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Byte address width on both sides
`define MPU_ADDR_W 32

// Read and write data width
`define MPU_DATA_W 32

//////////////////////////////////////////////////////////////////////
// PMA table and flow control
//////////////////////////////////////////////////////////////////////

// Entries in the fixed PMA table
`define MPU_PMA_REGIONS 4

// Bus responses that may be in flight
`define MPU_MAX_OUTSTANDING 4

`endif

// ==== rtl/mpu_cfg_pkg.sv ====
/*
  Fixed physical memory attribute table. Bounds are word addresses,
  low inclusive and high exclusive. Lower index wins on overlap.
  I/O regions must not be cacheable.
*/

`include "mpu_params.svh"

package mpu_cfg_pkg;

  // One PMA region with its attributes
  typedef struct packed {
    logic [`MPU_ADDR_W-3:0] word_addr_low;
    logic [`MPU_ADDR_W-3:0] word_addr_high;
    logic                   main;
    logic                   bufferable;
    logic                   cacheable;
  } pma_region_t;

  // Attributes for addresses outside every region
  localparam pma_region_t PMA_R_DEFAULT = '{
    word_addr_low:  '0,
    word_addr_high: '0,
    main:           1'b1,
    bufferable:     1'b0,
    cacheable:      1'b0
  };

  // Region 3 overlaps region 2 on purpose
  localparam pma_region_t PMA_CFG [0:`MPU_PMA_REGIONS-1] = '{
    // 0x0000_0000 .. 0x0001_0000, main memory
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_4000,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1},
    // 0x1000_0000 .. 0x1001_0000, I/O
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_4000,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0},
    // 0x2000_0000 .. 0x2004_0000, main memory
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0801_0000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b0},
    // 0x2000_0000 .. 0x3000_0000, I/O
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0C00_0000,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0}
  };

endpackage

// ==== rtl/mpu_txn_pkg.sv ====
/*
  Transaction types for the core and bus sides of the MPU.
  Both request channels use a valid/ready handshake. Responses are
  single-cycle pulses without back-pressure.
*/

`include "mpu_params.svh"

package mpu_txn_pkg;

  // Access size of a core request
  typedef enum logic [1:0] {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd2
  } mem_size_e;

  // Status returned with every core response
  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  // Controller states
  typedef enum logic [1:0] {
    MPU_IDLE     = 2'd0,
    MPU_ERR_WAIT = 2'd1,
    MPU_ERR_RESP = 2'd2
  } mpu_state_e;

  typedef struct packed {
    logic [`MPU_ADDR_W-1:0] addr;
    logic                   we;
    logic                   instr_fetch;
    mem_size_e              size;
    logic [`MPU_DATA_W-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic [`MPU_ADDR_W-1:0] addr;
    logic                   we;
    logic [`MPU_DATA_W-1:0] wdata;
    logic                   bufferable;
    logic                   cacheable;
  } bus_req_t;

  typedef struct packed {
    logic [`MPU_DATA_W-1:0] rdata;
    logic                   err;
  } bus_resp_t;

  typedef struct packed {
    logic [`MPU_DATA_W-1:0] rdata;
    mpu_status_e            status;
  } core_resp_t;

endpackage

// ==== rtl/mpu_pma_lookup.sv ====
/*
  Combinational PMA check of the current core request.
  allow_o and deny_o are not qualified by any handshake; the caller
  must combine them with a transfer. A misaligned access is checked
  against the region of its first byte only.
*/

`timescale 1ns/1ps

`include "mpu_params.svh"

module mpu_pma_lookup
  import mpu_cfg_pkg::*;
  import mpu_txn_pkg::*;
(
  input  core_req_t core_req_i,
  output bus_req_t  lookup_o,
  output logic      allow_o,
  output logic      deny_o
);

  logic [`MPU_ADDR_W-3:0] word_addr;
  pma_region_t            region;
  logic                   misaligned;
  logic                   pma_err;

  assign word_addr = core_req_i.addr[`MPU_ADDR_W-1:2];

  //////////////////////////////////////////////////////////////////////
  // Region search
  //////////////////////////////////////////////////////////////////////

  // Scan from the top so the lowest matching index is left standing
  always_comb begin
    region = PMA_R_DEFAULT;
    for (int i = `MPU_PMA_REGIONS - 1; i >= 0; i--) begin
      if ((word_addr >= PMA_CFG[i].word_addr_low) &&
          (word_addr < PMA_CFG[i].word_addr_high)) begin
        region = PMA_CFG[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fault decision
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (core_req_i.size)
      MEM_HALF: misaligned = core_req_i.addr[0];
      MEM_WORD: misaligned = |core_req_i.addr[1:0];
      default:  misaligned = 1'b0;
    endcase
  end

  // I/O space takes neither fetches nor misaligned accesses
  assign pma_err = !region.main && (core_req_i.instr_fetch || misaligned);

  assign allow_o = !pma_err;
  assign deny_o  = pma_err;

  //////////////////////////////////////////////////////////////////////
  // Bus request with attributes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    lookup_o.addr       = core_req_i.addr;
    lookup_o.we         = core_req_i.we;
    lookup_o.wdata      = core_req_i.wdata;
    // Loads are never bufferable
    lookup_o.bufferable = region.bufferable && core_req_i.we;
    lookup_o.cacheable  = region.cacheable;
  end

endmodule

// ==== rtl/mpu_bus_stage.sv ====
/*
  Single-entry holding stage toward the bus.
  load_i must only be raised while stage_free_o is high. The held
  request stays stable until the bus takes it.
*/

`timescale 1ns/1ps

module mpu_bus_stage
  import mpu_txn_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Load side, from the lookup and the controller
  input  logic     load_i,
  input  bus_req_t req_i,

  // Bus request channel
  output bus_req_t bus_req_o,
  output logic     bus_valid_o,
  input  logic     bus_ready_i,

  // Stage can take a load this cycle
  output logic     stage_free_o
);

  logic     valid_q;
  bus_req_t req_q;

  // Free when empty, or when the held request leaves this cycle
  assign stage_free_o = !valid_q || bus_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      valid_q <= 1'b1;
    end else if (bus_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on a load
  always_ff @(posedge clk) begin
    if (load_i) begin
      req_q <= req_i;
    end
  end

  assign bus_req_o   = req_q;
  assign bus_valid_o = valid_q;

endmodule

// ==== rtl/mpu_ctrl.sv ====
/*
  MPU controller. A denied request blocks the core, waits for all
  issued bus transactions to answer, then returns one fault response.
  A bus response with err set is reported as MPU_RE_FAULT, since the
  direction of issued transactions is not tracked.
*/

`timescale 1ns/1ps

`include "mpu_params.svh"

module mpu_ctrl
  import mpu_txn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // Core request handshake
  input  logic       core_valid_i,
  output logic       core_ready_o,

  // Lookup result for the current request
  input  logic       allow_i,
  input  logic       deny_i,
  input  logic       we_i,

  // Bus stage control
  input  logic       stage_free_i,
  output logic       take_o,
  input  logic       bus_issue_i,

  // Responses
  input  bus_resp_t  bus_resp_i,
  input  logic       bus_resp_valid_i,
  output core_resp_t core_resp_o,
  output logic       core_resp_valid_o
);

  // Room for the limit plus one request still held in the stage
  localparam int              CNT_W   = $clog2(`MPU_MAX_OUTSTANDING + 2);
  localparam logic [CNT_W-1:0] MAX_OUT = CNT_W'(`MPU_MAX_OUTSTANDING);

  mpu_state_e       state_q;
  mpu_state_e       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic             err_we_q;
  logic             active_q;
  logic             accept;

  //////////////////////////////////////////////////////////////////////
  // Core side handshake
  //////////////////////////////////////////////////////////////////////

  // active_q keeps the core blocked until the first cycle after reset
  assign core_ready_o = active_q && (state_q == MPU_IDLE) && stage_free_i &&
                        (cnt_q < MAX_OUT);

  assign accept = core_valid_i && core_ready_o;
  assign take_o = accept && allow_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  // Issued but unanswered bus transactions
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({bus_issue_i, bus_resp_valid_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Error sequencing FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MPU_IDLE: begin
        if (accept && deny_i) begin
          state_d = MPU_ERR_WAIT;
        end
      end
      // Earlier requests answer first to keep response order
      MPU_ERR_WAIT: begin
        if (cnt_q == '0) begin
          state_d = MPU_ERR_RESP;
        end
      end
      MPU_ERR_RESP: state_d = MPU_IDLE;
      default:      state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= MPU_IDLE;
      err_we_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept && deny_i) begin
        err_we_q <= we_i;
      end
    end
  end

  // Single response stream; bus stays quiet while the fault is returned
  always_comb begin
    if (state_q == MPU_ERR_RESP) begin
      core_resp_o.rdata  = '0;
      core_resp_o.status = err_we_q ? MPU_WR_FAULT : MPU_RE_FAULT;
    end else begin
      core_resp_o.rdata  = bus_resp_i.rdata;
      core_resp_o.status = bus_resp_i.err ? MPU_RE_FAULT : MPU_OK;
    end
  end

  assign core_resp_valid_o = bus_resp_valid_i || (state_q == MPU_ERR_RESP);

endmodule

// ==== rtl/mpu_top.sv ====
/*
  MPU between a core request channel and the system bus.
  Permitted requests reach the bus one cycle after acceptance.
  Denied requests never reach the bus and end in a fault response.
*/

`timescale 1ns/1ps

module mpu_top
  import mpu_txn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // Core side
  input  core_req_t  core_req_i,
  input  logic       core_valid_i,
  output logic       core_ready_o,
  output core_resp_t core_resp_o,
  output logic       core_resp_valid_o,

  // Bus side
  output bus_req_t   bus_req_o,
  output logic       bus_valid_o,
  input  logic       bus_ready_i,
  input  bus_resp_t  bus_resp_i,
  input  logic       bus_resp_valid_i
);

  bus_req_t lookup;
  logic     allow;
  logic     deny;
  logic     stage_free;
  logic     take;
  logic     bus_issue;

  assign bus_issue = bus_valid_o && bus_ready_i;

  mpu_pma_lookup pma_lookup_i (
    .core_req_i (core_req_i),
    .lookup_o   (lookup),
    .allow_o    (allow),
    .deny_o     (deny)
  );

  mpu_bus_stage bus_stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_i       (take),
    .req_i        (lookup),
    .bus_req_o    (bus_req_o),
    .bus_valid_o  (bus_valid_o),
    .bus_ready_i  (bus_ready_i),
    .stage_free_o (stage_free)
  );

  // Write flag comes from the lookup result
  mpu_ctrl ctrl_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_valid_i      (core_valid_i),
    .core_ready_o      (core_ready_o),
    .allow_i           (allow),
    .deny_i            (deny),
    .we_i              (lookup.we),
    .stage_free_i      (stage_free),
    .take_o            (take),
    .bus_issue_i       (bus_issue),
    .bus_resp_i        (bus_resp_i),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .core_resp_o       (core_resp_o),
    .core_resp_valid_o (core_resp_valid_o)
  );

endmodule

// ==== bench/mpu_checker.sv ====
/*
  Concurrent assertions on the MPU top-level handshakes, bound into
  mpu_top. Outstanding counts are rebuilt from the core and bus
  handshakes.
*/

`timescale 1ns/1ps

module mpu_checker
  import mpu_txn_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     core_valid_i,
  input logic     core_ready_i,
  input logic     core_resp_valid_i,
  input bus_req_t bus_req_i,
  input logic     bus_valid_i,
  input logic     bus_ready_i,
  input logic     bus_resp_valid_i
);

  int unsigned assert_fails = 0;
  int          outstanding;
  int          core_pending;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding  <= 0;
      core_pending <= 0;
    end else begin
      outstanding  <= outstanding + int'(bus_valid_i && bus_ready_i) - int'(bus_resp_valid_i);
      core_pending <= core_pending + int'(core_valid_i && core_ready_i) -
                      int'(core_resp_valid_i);
    end
  end

  bus_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    bus_valid_i && !bus_ready_i |=> bus_valid_i && $stable(bus_req_i))
    else begin
      $error("Bus request changed or dropped while stalled");
      assert_fails++;
    end

  reset_ready_a: assert property (@(posedge clk) !rst_n |-> !core_ready_i)
    else begin
      $error("Core ready high during reset");
      assert_fails++;
    end

  // Every core response answers an accepted core request
  resp_outstanding_a: assert property (@(posedge clk) disable iff (!rst_n)
    core_resp_valid_i |-> core_pending > 0)
    else begin
      $error("Core response with no accepted request outstanding");
      assert_fails++;
    end

  // Fault responses only once the bus has drained
  fault_drained_a: assert property (@(posedge clk) disable iff (!rst_n)
    core_resp_valid_i && !bus_resp_valid_i |-> outstanding == 0)
    else begin
      $error("Fault response while bus transactions are outstanding");
      assert_fails++;
    end

endmodule

bind mpu_top mpu_checker checker_i (
  .clk               (clk),
  .rst_n             (rst_n),
  .core_valid_i      (core_valid_i),
  .core_ready_i      (core_ready_o),
  .core_resp_valid_i (core_resp_valid_o),
  .bus_req_i         (bus_req_o),
  .bus_valid_i       (bus_valid_o),
  .bus_ready_i       (bus_ready_i),
  .bus_resp_valid_i  (bus_resp_valid_i)
);

// ==== bench/mpu_monitor.sv ====
/*
  Scoreboard for the MPU. Predicts each accepted core request from the
  PMA table and checks bus requests and core responses in order.
  Read data of fault responses is not compared.
*/

`timescale 1ns/1ps

`include "mpu_params.svh"

module mpu_monitor
  import mpu_cfg_pkg::*;
  import mpu_txn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  core_req_t   core_req_i,
  input  logic        core_valid_i,
  input  logic        core_ready_i,
  input  core_resp_t  core_resp_i,
  input  logic        core_resp_valid_i,
  input  bus_req_t    bus_req_i,
  input  logic        bus_valid_i,
  input  logic        bus_ready_i,
  input  logic        test_end_i,
  input  int          test_num_i,
  output int unsigned pending_o,
  output int unsigned err_count_o,
  output int unsigned check_count_o
);

  typedef struct packed {
    logic        allowed;
    logic        bufferable;
    logic        cacheable;
    mpu_status_e status;
  } outcome_t;

  typedef struct packed {
    mpu_status_e            status;
    logic [`MPU_DATA_W-1:0] rdata;
  } exp_resp_t;

  bus_req_t    bus_q [$];
  exp_resp_t   resp_q [$];
  int unsigned errors      = 0;
  int unsigned checks      = 0;
  int unsigned test_errors = 0;
  int unsigned test_checks = 0;

  // Expected outcome from the region table, byte address compare
  function automatic outcome_t predict(input core_req_t req);
    outcome_t    res;
    pma_region_t hit;
    logic        found;
    logic        misaligned;
    hit   = PMA_R_DEFAULT;
    found = 1'b0;
    for (int i = 0; i < `MPU_PMA_REGIONS; i++) begin
      if (!found && (req.addr >= {PMA_CFG[i].word_addr_low, 2'b00}) &&
          (req.addr < {PMA_CFG[i].word_addr_high, 2'b00})) begin
        hit   = PMA_CFG[i];
        found = 1'b1;
      end
    end
    misaligned = ((req.size == MEM_HALF) && ((req.addr % 2) != 0)) ||
                 ((req.size == MEM_WORD) && ((req.addr % 4) != 0));
    res.allowed    = hit.main || !(req.instr_fetch || misaligned);
    res.bufferable = hit.bufferable && req.we;
    res.cacheable  = hit.cacheable;
    if (res.allowed) begin
      res.status = MPU_OK;
    end else begin
      res.status = req.we ? MPU_WR_FAULT : MPU_RE_FAULT;
    end
    return res;
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1:       return "region match";
      2:       return "faults";
      3:       return "response data";
      4:       return "ordering";
      default: return "mixed traffic";
    endcase
  endfunction

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  always @(posedge clk) begin
    outcome_t  outcome;
    bus_req_t  exp_bus;
    exp_resp_t exp_resp;
    if (rst_n) begin
      if (core_valid_i && core_ready_i) begin
        outcome = predict(core_req_i);
        if (outcome.allowed) begin
          exp_bus.addr       = core_req_i.addr;
          exp_bus.we         = core_req_i.we;
          exp_bus.wdata      = core_req_i.wdata;
          exp_bus.bufferable = outcome.bufferable;
          exp_bus.cacheable  = outcome.cacheable;
          bus_q.push_back(exp_bus);
          exp_resp.rdata = ~core_req_i.addr;
        end else begin
          exp_resp.rdata = '0;
        end
        exp_resp.status = outcome.status;
        resp_q.push_back(exp_resp);
      end

      if (bus_valid_i && bus_ready_i) begin
        if (bus_q.size() == 0) begin
          $display("Bus request to %h at %0t had no permitted core request behind it",
                   bus_req_i.addr, $time);
          count_error();
        end else begin
          exp_bus = bus_q.pop_front();
          checks++;
          test_checks++;
          if (bus_req_i !== exp_bus) begin
            $display("error at %0t: bus request %h we %b wdata %h buf %b cache %b, %s",
                     $time, bus_req_i.addr, bus_req_i.we, bus_req_i.wdata,
                     bus_req_i.bufferable, bus_req_i.cacheable, "mismatch");
            $display("error at %0t: expected %h we %b wdata %h buf %b cache %b",
                     $time, exp_bus.addr, exp_bus.we, exp_bus.wdata,
                     exp_bus.bufferable, exp_bus.cacheable);
            count_error();
          end
        end
      end

      if (core_resp_valid_i) begin
        if (resp_q.size() == 0) begin
          $display("Core response with status %0d at %0t had no request waiting for it",
                   core_resp_i.status, $time);
          count_error();
        end else begin
          exp_resp = resp_q.pop_front();
          checks++;
          test_checks++;
          if ((core_resp_i.status !== exp_resp.status) ||
              ((exp_resp.status == MPU_OK) && (core_resp_i.rdata !== exp_resp.rdata))) begin
            $display("error at %0t: core response status %0d rdata %h, expected %0d rdata %h",
                     $time, core_resp_i.status, core_resp_i.rdata,
                     exp_resp.status, exp_resp.rdata);
            count_error();
          end
        end
      end

      if (test_end_i) begin
        $display("Test %0d %s: %s, %0d checks, %0d errors", test_num_i,
                 test_name(test_num_i), (test_errors == 0) ? "PASS" : "FAIL",
                 test_checks, test_errors);
        test_errors = 0;
        test_checks = 0;
      end
    end
    pending_o     <= resp_q.size();
    err_count_o   <= errors;
    check_count_o <= checks;
  end

endmodule

// ==== bench/mpu_tb.sv ====
/*
  Testbench for the MPU. Runs five tests through the core port and
  answers bus requests in order after 0 to 3 cycles, never with err.
  Stimulus is seeded once, so every run repeats exactly.
*/

`timescale 1ns/1ps

`include "mpu_params.svh"

module mpu_tb
  import mpu_txn_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 10;
  localparam int N_REGION        = 20;
  localparam int N_FAULT         = 14;
  localparam int N_DATA          = 8;
  localparam int N_ORDER         = 30;
  localparam int N_MIXED         = 200;
  localparam int N_TOTAL         = N_REGION + N_FAULT + N_DATA + N_ORDER + N_MIXED;
  localparam int WATCHDOG_CYCLES = N_TOTAL * 20 + 500;

  // One address per region edge, the overlap and unmapped space
  localparam logic [`MPU_ADDR_W-1:0] REGION_ADDRS [10] = '{
    32'h0000_0100, 32'h0000_FFFC, 32'h1000_0040, 32'h2000_0010, 32'h2003_FFFC,
    32'h2004_0000, 32'h2FFF_FFFC, 32'h4000_0000, 32'h0001_0000, 32'h1001_0000
  };
  localparam logic [`MPU_ADDR_W-1:0] IO_ADDRS [2] = '{32'h1000_0080, 32'h2800_0000};

  logic        clk;
  logic        rst_n;
  core_req_t   core_req;
  logic        core_valid;
  logic        core_ready;
  core_resp_t  core_resp;
  logic        core_resp_valid;
  bus_req_t    bus_req;
  logic        bus_valid;
  logic        bus_ready;
  bus_resp_t   bus_resp;
  logic        bus_resp_valid;

  int unsigned stall_pct;
  int          test_num;
  logic        test_end;
  int unsigned pending;
  int unsigned err_count;
  int unsigned check_count;
  int unsigned bus_cycle = 0;

  // Accepted bus requests waiting for their response
  logic [`MPU_ADDR_W-1:0] resp_addr_q [$];
  int unsigned            resp_due_q [$];

  mpu_top mpu_top_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_i        (core_req),
    .core_valid_i      (core_valid),
    .core_ready_o      (core_ready),
    .core_resp_o       (core_resp),
    .core_resp_valid_o (core_resp_valid),
    .bus_req_o         (bus_req),
    .bus_valid_o       (bus_valid),
    .bus_ready_i       (bus_ready),
    .bus_resp_i        (bus_resp),
    .bus_resp_valid_i  (bus_resp_valid)
  );

  mpu_monitor monitor_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_i        (core_req),
    .core_valid_i      (core_valid),
    .core_ready_i      (core_ready),
    .core_resp_i       (core_resp),
    .core_resp_valid_i (core_resp_valid),
    .bus_req_i         (bus_req),
    .bus_valid_i       (bus_valid),
    .bus_ready_i       (bus_ready),
    .test_end_i        (test_end),
    .test_num_i        (test_num),
    .pending_o         (pending),
    .err_count_o       (err_count),
    .check_count_o     (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Bus responder model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    bus_cycle = bus_cycle + 1;
    if (!rst_n) begin
      bus_ready      <= 1'b0;
      bus_resp_valid <= 1'b0;
    end else begin
      if (bus_valid && bus_ready) begin
        resp_addr_q.push_back(bus_req.addr);
        resp_due_q.push_back(bus_cycle + ($urandom % 4));
      end
      bus_ready <= (($urandom % 100) >= stall_pct);
      // One answer per cycle, oldest first
      if ((resp_due_q.size() > 0) && (resp_due_q[0] <= bus_cycle)) begin
        bus_resp_valid <= 1'b1;
        bus_resp.rdata <= ~resp_addr_q.pop_front();
        bus_resp.err   <= 1'b0;
        void'(resp_due_q.pop_front());
      end else begin
        bus_resp_valid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic core_req_t make_req(input logic [`MPU_ADDR_W-1:0] addr, input logic we,
                                         input logic fetch, input mem_size_e size);
    core_req_t req;
    req.addr        = addr;
    req.we          = we;
    req.instr_fetch = fetch;
    req.size        = size;
    req.wdata       = $urandom;
    return req;
  endfunction

  function automatic logic [`MPU_ADDR_W-1:0] rand_addr();
    logic [`MPU_ADDR_W-1:0] addr;
    case ($urandom % 6)
      0:       addr = $urandom % 32'h0001_0000;
      1:       addr = 32'h1000_0000 + ($urandom % 32'h0001_0000);
      2:       addr = 32'h2000_0000 + ($urandom % 32'h0004_0000);
      3:       addr = 32'h2004_0000 + ($urandom % 32'h0FFC_0000);
      4:       addr = 32'h4000_0000 + ($urandom % 32'h1000_0000);
      default: addr = $urandom;
    endcase
    return addr;
  endfunction

  function automatic core_req_t rand_req();
    logic we;
    logic fetch;
    we    = $urandom % 2;
    fetch = !we && (($urandom % 8) == 0);
    return make_req(rand_addr(), we, fetch, mem_size_e'($urandom % 3));
  endfunction

  // Called at a rising edge; returns at the edge of the transfer
  task automatic send_req(input core_req_t req);
    core_req   <= req;
    core_valid <= 1'b1;
    @(posedge clk);
    while (!core_ready) begin
      @(posedge clk);
    end
    core_valid <= 1'b0;
  endtask

  task automatic idle_gap(input int unsigned max_gap);
    int unsigned n;
    n = $urandom % (max_gap + 1);
    repeat (n) @(posedge clk);
  endtask

  // Drain all expected responses, then let the monitor report
  task automatic finish_test(input int num);
    do begin
      @(posedge clk);
    end while (pending != 0);
    test_num <= num;
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [`MPU_ADDR_W-1:0] base;
    logic [`MPU_ADDR_W-1:0] addr;
    rst_n          = 1'b0;
    core_req       = '0;
    core_valid     = 1'b0;
    bus_ready      = 1'b0;
    bus_resp       = '0;
    bus_resp_valid = 1'b0;
    stall_pct      = 0;
    test_num       = 0;
    test_end       = 1'b0;
    void'($urandom(32'h08cf_5f79));
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Region match
    stall_pct <= 20;
    for (int i = 0; i < 10; i++) begin
      for (int w = 0; w < 2; w++) begin
        send_req(make_req(REGION_ADDRS[i], w[0], 1'b0, MEM_WORD));
        idle_gap(1);
      end
    end
    finish_test(1);

    // Faults in I/O space, then legal accesses around them
    for (int i = 0; i < 2; i++) begin
      base = IO_ADDRS[i];
      send_req(make_req(base, 1'b0, 1'b1, MEM_WORD));
      send_req(make_req(base + 1, 1'b1, 1'b0, MEM_WORD));
      send_req(make_req(base + 1, 1'b0, 1'b0, MEM_HALF));
      send_req(make_req(base + 2, 1'b1, 1'b0, MEM_WORD));
      send_req(make_req(base + 3, 1'b0, 1'b0, MEM_BYTE));
      send_req(make_req(base + 2, 1'b1, 1'b0, MEM_HALF));
    end
    send_req(make_req(32'h0000_0200, 1'b0, 1'b1, MEM_WORD));
    send_req(make_req(32'h2000_0101, 1'b1, 1'b0, MEM_WORD));
    finish_test(2);

    // Read data from main memory
    for (int i = 0; i < N_DATA; i++) begin
      if ((i % 2) == 0) begin
        addr = $urandom % 32'h0001_0000;
      end else begin
        addr = 32'h2000_0000 + ($urandom % 32'h0004_0000);
      end
      addr[1:0] = 2'b00;
      send_req(make_req(addr, 1'b0, 1'b0, MEM_WORD));
      idle_gap(2);
    end
    finish_test(3);

    // Back-to-back traffic under heavy stalls
    stall_pct <= 70;
    for (int i = 0; i < N_ORDER; i++) begin
      send_req(rand_req());
    end
    finish_test(4);

    stall_pct <= 40;
    for (int i = 0; i < N_MIXED; i++) begin
      send_req(rand_req());
      idle_gap(2);
    end
    finish_test(5);

    $display("Tests 5, checks %0d, errors %0d, assertion failures %0d",
             check_count, err_count, mpu_top_i.checker_i.assert_fails);
    if ((err_count == 0) && (mpu_top_i.checker_i.assert_fails == 0)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the traffic never completed",
             WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/mpu_cfg_pkg.sv
rtl/mpu_txn_pkg.sv
rtl/mpu_pma_lookup.sv
rtl/mpu_bus_stage.sv
rtl/mpu_ctrl.sv
rtl/mpu_top.sv
bench/mpu_checker.sv
bench/mpu_monitor.sv
bench/mpu_tb.sv

// ==== Bender.yml ====
package:
  name: mpu

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mpu_cfg_pkg.sv
      - rtl/mpu_txn_pkg.sv
      - rtl/mpu_pma_lookup.sv
      - rtl/mpu_bus_stage.sv
      - rtl/mpu_ctrl.sv
      - rtl/mpu_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - bench/mpu_checker.sv
      - bench/mpu_monitor.sv
      - bench/mpu_tb.sv
